// File: eth_mux.f
+incdir+src
src/eth_mux_pkg.sv
src/eth_mux_arbiter.sv
src/eth_mux_skid_buffer.sv
src/eth_mux.sv
test/eth_mux_checker.sv
test/eth_mux_tb.sv

// File: test/eth_mux_cases.txt
// enable_select_midselect_port_beats_backpressure_destmac_srcmac_ethtype_lastkeep_lastuser_seed
// one frame per line, every field in hex
1_0_0_0_4_0_0a0000000001_020000000001_0800_0f_0_0011
1_1_1_1_1_0_0a0000000002_020000000002_86dd_01_1_0022
1_2_2_2_8_1_0a0000000003_020000000003_0800_ff_0_0033
1_3_3_3_5_1_0a0000000004_020000000004_8100_3f_1_0044
1_1_1_2_3_0_0a0000000005_020000000005_0800_0f_0_0055
0_0_0_0_3_0_0a0000000006_020000000006_0800_0f_0_0066
1_2_0_2_6_0_0a0000000007_020000000007_88cc_1f_1_0077
1_0_3_0_8_1_0a0000000008_020000000008_0806_7f_0_0088
0_3_3_3_2_1_0a0000000009_020000000009_0800_0f_0_0099
1_3_3_0_4_0_0a000000000a_02000000000a_0800_0f_0_00aa
1_1_2_1_2_1_0a000000000b_02000000000b_86dd_07_1_00bb
1_2_2_2_3_0_0a000000000c_02000000000c_0800_80_1_00cc
1_1_0_1_7_1_0a000000000d_02000000000d_8100_03_0_00dd

// File: test/eth_mux_tb.sv
// frame mux testbench: replays frame cases, models the expected stream and checks it
`timescale 1ns/10ps
`include "eth_mux_defs.svh"

module eth_mux_tb;
    import eth_mux_pkg::*;

    // one line of the cases file
    typedef struct packed {
        logic [3:0]                 enable;
        logic [3:0]                 select;
        logic [3:0]                 mid_select;
        logic [3:0]                 port;
        logic [3:0]                 beats;
        logic [3:0]                 backpressure;
        logic [`ETH_MUX_MAC_W-1:0]  dest_mac;
        logic [`ETH_MUX_MAC_W-1:0]  src_mac;
        logic [`ETH_MUX_TYPE_W-1:0] eth_type;
        logic [`ETH_MUX_KEEP_W-1:0] last_keep;
        logic [3:0]                 last_user;
        logic [15:0]                seed;
    } frame_case_t;

    localparam int MAX_CASES = 32;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      enable;
    logic [`ETH_MUX_SEL_W-1:0] select;
    eth_hdr_t                  in_hdr [`ETH_MUX_PORTS];
    logic [`ETH_MUX_PORTS-1:0] in_hdr_valid;
    logic [`ETH_MUX_PORTS-1:0] in_hdr_ready;
    eth_beat_t                 in_beat [`ETH_MUX_PORTS];
    logic [`ETH_MUX_PORTS-1:0] in_tvalid;
    logic [`ETH_MUX_PORTS-1:0] in_tready;
    eth_hdr_t                  out_hdr;
    logic                      out_hdr_valid;
    logic                      out_hdr_ready;
    eth_beat_t                 out_beat;
    logic                      out_tvalid;
    logic                      out_tready;

    logic [$bits(frame_case_t)-1:0] case_mem [MAX_CASES];
    logic                      cases_ready = 1'b0;
    int                        n_cases;
    int                        value_errors;
    int                        proto_errors;
    int                        beats_seen;
    // scoreboard
    eth_beat_t                 exp_q [$];
    eth_beat_t                 exp_beat;
    eth_hdr_t                  exp_hdr;
    logic                      hdr_pending;
    logic [`ETH_MUX_PORTS-1:0] allow_mask;
    logic                      bp_on;
    logic [31:0]               bp_state;

    eth_mux dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // offer one frame on its port, then wait until the expected output has drained
    task automatic run_case(input frame_case_t fc);
        eth_beat_t   beats [8];
        eth_hdr_t    hdr;
        logic [31:0] state;
        logic        accept;
        logic        go;
        int          p;
        int          n;
        int          i;
        p = fc.port;
        n = fc.beats;
        state = 32'h65f5 + fc.seed;
        for (i = 0; i < n; i++) begin
            state = lcg_next(state);
            beats[i].tdata[63:32] = state;
            state = lcg_next(state);
            beats[i].tdata[31:0] = state;
            beats[i].tkeep = '1;
            beats[i].tlast = 1'b0;
            beats[i].tuser = 1'b0;
        end
        beats[n-1].tkeep = fc.last_keep;
        beats[n-1].tlast = 1'b1;
        beats[n-1].tuser = fc.last_user[0];
        hdr.dest_mac = fc.dest_mac;
        hdr.src_mac  = fc.src_mac;
        hdr.eth_type = fc.eth_type;
        accept = fc.enable[0] && (fc.select == fc.port);

        @(negedge clk);
        bp_on = fc.backpressure[0];
        allow_mask = '0;
        if (accept) begin
            allow_mask[p] = 1'b1;
            exp_hdr = hdr;
            hdr_pending = 1'b1;
            for (i = 0; i < n; i++) begin
                exp_q.push_back(beats[i]);
            end
        end
        enable = fc.enable[0];
        select = fc.select[`ETH_MUX_SEL_W-1:0];
        in_hdr[p] = hdr;
        in_hdr_valid[p] = 1'b1;
        in_beat[p] = beats[0];
        in_tvalid[p] = 1'b1;

        if (!accept) begin
            // nothing may happen while the offer stays pending
            repeat (12) @(negedge clk);
        end else begin
            while (!in_hdr_ready[p]) @(negedge clk);
            // source is captured now so a new select must not matter
            select = fc.mid_select[`ETH_MUX_SEL_W-1:0];
            i = 0;
            while (i < n) begin
                go = in_tready[p];
                @(negedge clk);
                in_hdr_valid[p] = 1'b0;
                if (go) begin
                    i++;
                    if (i < n) begin
                        in_beat[p] = beats[i];
                    end
                end
            end
        end
        in_hdr_valid[p] = 1'b0;
        in_tvalid[p] = 1'b0;
        while (exp_q.size() != 0 || hdr_pending) @(negedge clk);
    endtask

    // drive the output readies and check everything that leaves the mux
    always @(negedge clk) begin
        if (!rst) begin
            if (bp_on) begin
                bp_state = lcg_next(bp_state);
                out_tready = bp_state[16];
                out_hdr_ready = bp_state[24];
            end else begin
                out_tready = 1'b1;
                out_hdr_ready = 1'b1;
            end
            assert ((in_tready & ~allow_mask) == '0)
            else begin
                proto_errors++;
                $display("in_tready went to a port that owns no frame at %0t", $time);
            end
            assert ((in_hdr_ready & ~allow_mask) == '0)
            else begin
                proto_errors++;
                $display("in_hdr_ready went to a port that owns no frame at %0t", $time);
            end
            if (out_hdr_valid) begin
                assert (hdr_pending)
                else begin
                    proto_errors++;
                    $display("a header left the mux with no frame accepted at %0t", $time);
                end
                assert (out_hdr == exp_hdr)
                else begin
                    value_errors++;
                    $display("error at %0t: out_hdr is %h, expected %h", $time, out_hdr, exp_hdr);
                end
                if (out_hdr_ready) begin
                    hdr_pending = 1'b0;
                end
            end
            if (out_tvalid && out_tready) begin
                assert (exp_q.size() != 0)
                else begin
                    proto_errors++;
                    $display("a payload beat left the mux when none was due at %0t", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_beat = exp_q.pop_front();
                    beats_seen++;
                    assert (out_beat == exp_beat)
                    else begin
                        value_errors++;
                        $display("error at %0t: out_beat is %h, expected %h",
                                 $time, out_beat, exp_beat);
                    end
                end
            end
        end
    end

    // watchdog sized from the number of cases
    initial begin
        wait (cases_ready);
        #((n_cases * (8 * 4 + 60) + 16) * 8);
        $display("timeout: the frame cases did not complete in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        frame_case_t fc;
        int          k;
        value_errors = 0;
        proto_errors = 0;
        beats_seen = 0;
        n_cases = 0;
        hdr_pending = 1'b0;
        allow_mask = '0;
        bp_on = 1'b0;
        bp_state = 32'h65f5;
        rst = 1'b1;
        enable = 1'b0;
        select = '0;
        in_hdr_valid = '0;
        in_tvalid = '0;
        out_hdr_ready = 1'b1;
        out_tready = 1'b1;
        for (k = 0; k < `ETH_MUX_PORTS; k++) begin
            in_hdr[k] = '0;
            in_beat[k] = '0;
        end
        $readmemh("test/eth_mux_cases.txt", case_mem);
        while (n_cases < MAX_CASES && !$isunknown(case_mem[n_cases])) n_cases++;
        cases_ready = 1'b1;
        if (n_cases == 0) begin
            proto_errors++;
            $display("no frame cases could be read from test/eth_mux_cases.txt");
        end

        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (k = 0; k < n_cases; k++) begin
            fc = case_mem[k];
            run_case(fc);
        end
        repeat (4) @(negedge clk);

        $display("summary: %0d cases, %0d beats, errors %0d value, %0d protocol, %0d checker",
                 n_cases, beats_seen, value_errors, proto_errors, dut.u_checker.fail_count);
        if (value_errors + proto_errors + dut.u_checker.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: test/eth_mux_checker.sv
// handshake checker: output hold under stall, single served port, quiet outputs in reset
`timescale 1ns/10ps
`include "eth_mux_defs.svh"

module eth_mux_checker (
    input logic                      clk,
    input logic                      rst,
    input eth_mux_pkg::eth_hdr_t     out_hdr,
    input logic                      out_hdr_valid,
    input logic                      out_hdr_ready,
    input eth_mux_pkg::eth_beat_t    out_beat,
    input logic                      out_tvalid,
    input logic                      out_tready,
    input logic [`ETH_MUX_PORTS-1:0] in_tready,
    input logic [`ETH_MUX_PORTS-1:0] in_hdr_ready
);
    // failure count read by the testbench at the end
    int fail_count = 0;

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr))
    else begin
        fail_count++;
        $error("out_hdr or out_hdr_valid changed while the header was stalled");
    end

    beat_hold: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_beat))
    else begin
        fail_count++;
        $error("out_beat or out_tvalid changed while the payload was stalled");
    end

    // header and payload readies never point at two ports at once
    one_port: assert property (@(posedge clk) disable iff (rst)
        $onehot0(in_tready | in_hdr_ready))
    else begin
        fail_count++;
        $error("input ready signals are high on more than one port");
    end

    // checked while reset itself is asserted
    reset_quiet: assert property (@(posedge clk)
        rst |-> !out_tvalid && !out_hdr_valid && in_tready == '0 && in_hdr_ready == '0)
    else begin
        fail_count++;
        $error("an output handshake signal is high during reset");
    end

endmodule

bind eth_mux eth_mux_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .out_hdr      (out_hdr),
    .out_hdr_valid(out_hdr_valid),
    .out_hdr_ready(out_hdr_ready),
    .out_beat     (out_beat),
    .out_tvalid   (out_tvalid),
    .out_tready   (out_tready),
    .in_tready    (in_tready),
    .in_hdr_ready (in_hdr_ready)
);

// File: src/eth_mux.sv
// four-port ethernet frame mux with a 64-bit payload path
`timescale 1ns/10ps
`include "eth_mux_defs.svh"

module eth_mux (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enable,
    input  logic [`ETH_MUX_SEL_W-1:0]     select,
    input  eth_mux_pkg::eth_hdr_t         in_hdr [`ETH_MUX_PORTS],
    input  logic [`ETH_MUX_PORTS-1:0]     in_hdr_valid,
    output logic [`ETH_MUX_PORTS-1:0]     in_hdr_ready,
    input  eth_mux_pkg::eth_beat_t        in_beat [`ETH_MUX_PORTS],
    input  logic [`ETH_MUX_PORTS-1:0]     in_tvalid,
    output logic [`ETH_MUX_PORTS-1:0]     in_tready,
    output eth_mux_pkg::eth_hdr_t         out_hdr,
    output logic                          out_hdr_valid,
    input  logic                          out_hdr_ready,
    output eth_mux_pkg::eth_beat_t        out_beat,
    output logic                          out_tvalid,
    input  logic                          out_tready
);
    import eth_mux_pkg::*;

    // arbiter to skid buffer
    eth_beat_t mux_beat;
    logic      mux_valid;
    logic      ready_early;

    eth_mux_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .select       (select),
        .in_hdr       (in_hdr),
        .in_hdr_valid (in_hdr_valid),
        .in_hdr_ready (in_hdr_ready),
        .in_beat      (in_beat),
        .in_tvalid    (in_tvalid),
        .in_tready    (in_tready),
        .out_hdr      (out_hdr),
        .out_hdr_valid(out_hdr_valid),
        .out_hdr_ready(out_hdr_ready),
        .ready_early  (ready_early),
        .mux_beat     (mux_beat),
        .mux_valid    (mux_valid)
    );

    eth_mux_skid_buffer u_skid_buffer (
        .clk        (clk),
        .rst        (rst),
        .mux_beat   (mux_beat),
        .mux_valid  (mux_valid),
        .ready_early(ready_early),
        .out_beat   (out_beat),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready)
    );

endmodule

// File: src/eth_mux_skid_buffer.sv
// two-entry output payload stage, input ready registered one cycle ahead
`timescale 1ns/10ps

module eth_mux_skid_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_mux_pkg::eth_beat_t mux_beat,
    input  logic                   mux_valid,
    output logic                   ready_early,
    output eth_mux_pkg::eth_beat_t out_beat,
    output logic                   out_tvalid,
    input  logic                   out_tready
);
    import eth_mux_pkg::*;

    logic      ready_reg;
    eth_beat_t out_reg;
    logic      out_valid_reg;
    eth_beat_t tmp_reg;
    logic      tmp_valid_reg;

    // output drains beats directly from the output register
    logic      take_direct;

    assign out_beat   = out_reg;
    assign out_tvalid = out_valid_reg;

    assign take_direct = out_tready | ~out_valid_reg;

    // accept next cycle if the output drains now, both entries are free,
    // or the temp entry is free and nothing arrives this cycle
    assign ready_early = out_tready
                       | (~tmp_valid_reg & ~out_valid_reg)
                       | (~tmp_valid_reg & ~mux_valid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg     <= 1'b0;
            out_valid_reg <= 1'b0;
            tmp_valid_reg <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (ready_reg) begin
                if (take_direct) begin
                    out_valid_reg <= mux_valid;
                end else begin
                    // output stalled, park the beat
                    tmp_valid_reg <= mux_valid;
                end
            end else if (out_tready) begin
                // refill output from the parked beat
                out_valid_reg <= tmp_valid_reg;
                tmp_valid_reg <= 1'b0;
            end
        end
    end

    // beat contents follow the same routing as the valid bits
    always_ff @(posedge clk) begin
        if (ready_reg) begin
            if (take_direct) begin
                out_reg <= mux_beat;
            end else begin
                tmp_reg <= mux_beat;
            end
        end else if (out_tready) begin
            out_reg <= tmp_reg;
        end
    end

endmodule

// File: src/eth_mux_arbiter.sv
// frame arbiter: picks a port per frame, latches its header and muxes its payload
`timescale 1ns/10ps
`include "eth_mux_defs.svh"

module eth_mux_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enable,
    input  logic [`ETH_MUX_SEL_W-1:0]     select,
    input  eth_mux_pkg::eth_hdr_t         in_hdr [`ETH_MUX_PORTS],
    input  logic [`ETH_MUX_PORTS-1:0]     in_hdr_valid,
    output logic [`ETH_MUX_PORTS-1:0]     in_hdr_ready,
    input  eth_mux_pkg::eth_beat_t        in_beat [`ETH_MUX_PORTS],
    input  logic [`ETH_MUX_PORTS-1:0]     in_tvalid,
    output logic [`ETH_MUX_PORTS-1:0]     in_tready,
    output eth_mux_pkg::eth_hdr_t         out_hdr,
    output logic                          out_hdr_valid,
    input  logic                          out_hdr_ready,
    input  logic                          ready_early,
    output eth_mux_pkg::eth_beat_t        mux_beat,
    output logic                          mux_valid
);
    import eth_mux_pkg::*;

    frame_state_t                 state_reg;
    frame_state_t                 state_next;
    logic [`ETH_MUX_SEL_W-1:0]    sel_reg;
    logic [`ETH_MUX_SEL_W-1:0]    sel_next;
    logic [`ETH_MUX_PORTS-1:0]    hdr_ready_reg;
    logic [`ETH_MUX_PORTS-1:0]    hdr_ready_next;
    logic [`ETH_MUX_PORTS-1:0]    tready_reg;
    logic [`ETH_MUX_PORTS-1:0]    tready_next;
    eth_hdr_t                     hdr_reg;
    eth_hdr_t                     hdr_next;
    logic                         hdr_valid_reg;
    logic                         hdr_valid_next;

    // current source, fixed for the whole frame by the captured select
    eth_beat_t                    cur_beat;
    logic                         cur_tvalid;
    logic                         cur_tready;

    assign cur_beat   = in_beat[sel_reg];
    assign cur_tvalid = in_tvalid[sel_reg];
    assign cur_tready = tready_reg[sel_reg];

    assign in_hdr_ready  = hdr_ready_reg;
    assign in_tready     = tready_reg;
    assign out_hdr       = hdr_reg;
    assign out_hdr_valid = hdr_valid_reg;

    // beat goes to the skid buffer only when it really transfers
    assign mux_beat  = cur_beat;
    assign mux_valid = cur_tvalid & cur_tready & (state_reg == FRAME_ACTIVE);

    always_comb begin
        state_next     = state_reg;
        sel_next       = sel_reg;
        hdr_next       = hdr_reg;
        hdr_valid_next = hdr_valid_reg & ~out_hdr_ready;
        // header ready drops once the source has seen it with its valid
        hdr_ready_next = hdr_ready_reg & ~in_hdr_valid;
        tready_next    = '0;

        if (state_reg == FRAME_ACTIVE) begin
            // the last accepted beat closes the frame
            if (cur_tvalid && cur_tready && cur_beat.tlast) begin
                state_next = FRAME_IDLE;
            end
        end else if (enable && in_hdr_valid[select]) begin
            // start of frame, select is sampled here only
            state_next     = FRAME_ACTIVE;
            sel_next       = select;
            hdr_next       = in_hdr[select];
            hdr_valid_next = 1'b1;
        end

        if (state_next == FRAME_ACTIVE) begin
            tready_next[sel_next] = ready_early;
            if (state_reg == FRAME_IDLE) begin
                hdr_ready_next[sel_next] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_reg     <= FRAME_IDLE;
            sel_reg       <= '0;
            hdr_ready_reg <= '0;
            tready_reg    <= '0;
            hdr_valid_reg <= 1'b0;
        end else begin
            state_reg     <= state_next;
            sel_reg       <= sel_next;
            hdr_ready_reg <= hdr_ready_next;
            tready_reg    <= tready_next;
            hdr_valid_reg <= hdr_valid_next;
        end
    end

    // held output header, only meaningful under out_hdr_valid
    always_ff @(posedge clk) begin
        hdr_reg <= hdr_next;
    end

endmodule

// File: src/eth_mux_pkg.sv
// frame mux types: header, payload beat and frame state
`include "eth_mux_defs.svh"

package eth_mux_pkg;

    // header as offered by each port, dest_mac in the top bits
    typedef struct packed {
        logic [`ETH_MUX_MAC_W-1:0]  dest_mac;
        logic [`ETH_MUX_MAC_W-1:0]  src_mac;
        logic [`ETH_MUX_TYPE_W-1:0] eth_type;
    } eth_hdr_t;

    // one payload beat
    typedef struct packed {
        logic [`ETH_MUX_DATA_W-1:0] tdata;
        logic [`ETH_MUX_KEEP_W-1:0] tkeep;
        logic                       tlast;
        logic                       tuser;
    } eth_beat_t;

    // idle until a header is taken, active until the last beat
    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

endpackage

// File: src/eth_mux_defs.svh
// frame mux dimensions: port count, select width and field widths
`ifndef ETH_MUX_DEFS_SVH
`define ETH_MUX_DEFS_SVH

// four input ports, two select bits
`define ETH_MUX_PORTS 4
`define ETH_MUX_SEL_W 2

// payload beat, one keep bit per data byte
`define ETH_MUX_DATA_W 64
`define ETH_MUX_KEEP_W 8

// header fields
`define ETH_MUX_MAC_W 48
`define ETH_MUX_TYPE_W 16

`endif
